// ==== design/dual_issue_pkg.sv ====
package dual_issue_pkg;

    localparam int unsigned xlen        = 32;
    localparam int unsigned num_regs    = 32;
    localparam int unsigned reg_addr_w  = 5;
    localparam int unsigned issue_width = 2;   // Slots per decoded pair.
    localparam int unsigned uop_w       = 4;

    // Micro-op codes understood by the execute lanes.
    localparam logic [uop_w-1:0] uop_add = 4'h0;
    localparam logic [uop_w-1:0] uop_sub = 4'h1;
    localparam logic [uop_w-1:0] uop_and = 4'h2;
    localparam logic [uop_w-1:0] uop_or  = 4'h3;
    localparam logic [uop_w-1:0] uop_xor = 4'h4;
    localparam logic [uop_w-1:0] uop_sll = 4'h5;
    localparam logic [uop_w-1:0] uop_srl = 4'h6;
    localparam logic [uop_w-1:0] uop_lui = 4'h7;

    // One decoded instruction as handed over by decode.
    typedef struct packed {
        logic                  valid;
        logic                  excp;    // Exception flag, only carried to retire.
        logic [uop_w-1:0]      uop;
        logic                  use_imm;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rk;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       pc;
    } issue_slot_t;

    // Slot 0 sits in the low bits.
    typedef issue_slot_t [issue_width-1:0] issue_pair_t;

    // Operands already read, as one lane consumes them.
    typedef struct packed {
        logic                  valid;
        logic                  excp;
        logic [uop_w-1:0]      uop;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [xlen-1:0]       pc;
    } lane_op_t;

    typedef struct packed {
        logic                  valid;
        logic                  we;      // Set only without exception and with rd nonzero.
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic [xlen-1:0]       pc;
    } result_t;

endpackage

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 we0,
    input  logic [dual_issue_pkg::reg_addr_w-1:0] waddr0,
    input  logic [dual_issue_pkg::xlen-1:0]       wdata0,
    input  logic                                 we1,
    input  logic [dual_issue_pkg::reg_addr_w-1:0] waddr1,
    input  logic [dual_issue_pkg::xlen-1:0]       wdata1,
    input  logic [dual_issue_pkg::reg_addr_w-1:0] raddr0,
    input  logic [dual_issue_pkg::reg_addr_w-1:0] raddr1,
    input  logic [dual_issue_pkg::reg_addr_w-1:0] raddr2,
    input  logic [dual_issue_pkg::reg_addr_w-1:0] raddr3,
    output logic [dual_issue_pkg::xlen-1:0]       rdata0,
    output logic [dual_issue_pkg::xlen-1:0]       rdata1,
    output logic [dual_issue_pkg::xlen-1:0]       rdata2,
    output logic [dual_issue_pkg::xlen-1:0]       rdata3
);

    logic [dual_issue_pkg::xlen-1:0]       regs    [dual_issue_pkg::num_regs];
    logic [dual_issue_pkg::reg_addr_w-1:0] raddr_a [4];
    logic [dual_issue_pkg::xlen-1:0]       rdata_a [4];

    assign raddr_a[0] = raddr0;
    assign raddr_a[1] = raddr1;
    assign raddr_a[2] = raddr2;
    assign raddr_a[3] = raddr3;

    // Write-first reads. Port 1 is checked first so it wins a shared address.
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (raddr_a[i] == '0)
                rdata_a[i] = '0;
            else if (we1 && waddr1 == raddr_a[i])
                rdata_a[i] = wdata1;
            else if (we0 && waddr0 == raddr_a[i])
                rdata_a[i] = wdata0;
            else
                rdata_a[i] = regs[raddr_a[i]];
        end
    end

    assign rdata0 = rdata_a[0];
    assign rdata1 = rdata_a[1];
    assign rdata2 = rdata_a[2];
    assign rdata3 = rdata_a[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < dual_issue_pkg::num_regs; r++)
                regs[r] <= '0;
        end else begin
            if (we0 && waddr0 != '0)
                regs[waddr0] <= wdata0;
            if (we1 && waddr1 != '0)
                regs[waddr1] <= wdata1;   // Later assignment, so port 1 wins.
        end
    end

    a_r0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((we0 && waddr0 == '0) || (we1 && waddr1 == '0)) |=> regs[0] == '0);

endmodule

// ==== design/reg_read_stage.sv ====
`timescale 1ns/1ps

module reg_read_stage (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  flush,
    input  dual_issue_pkg::issue_pair_t           in_pair,
    input  logic                                  in_valid,
    output logic                                  in_allowin,
    input  logic                                  out_allowin,
    input  logic [dual_issue_pkg::num_regs-1:0]   pending,
    output logic [dual_issue_pkg::reg_addr_w-1:0] raddr0,
    output logic [dual_issue_pkg::reg_addr_w-1:0] raddr1,
    output logic [dual_issue_pkg::reg_addr_w-1:0] raddr2,
    output logic [dual_issue_pkg::reg_addr_w-1:0] raddr3,
    input  logic [dual_issue_pkg::xlen-1:0]       rdata0,
    input  logic [dual_issue_pkg::xlen-1:0]       rdata1,
    input  logic [dual_issue_pkg::xlen-1:0]       rdata2,
    input  logic [dual_issue_pkg::xlen-1:0]       rdata3,
    output dual_issue_pkg::lane_op_t              ex_op0,
    output dual_issue_pkg::lane_op_t              ex_op1,
    output logic                                  ex_go
);

    logic [dual_issue_pkg::num_regs-1:0]                   busy;
    logic                                                  hazard;
    logic                                                  load;
    logic [dual_issue_pkg::issue_width-1:0]                vld_d;
    logic [dual_issue_pkg::issue_width-1:0]                vld_q;
    dual_issue_pkg::lane_op_t [dual_issue_pkg::issue_width-1:0] op_d;
    dual_issue_pkg::lane_op_t [dual_issue_pkg::issue_width-1:0] op_q;
    logic [dual_issue_pkg::xlen-1:0]                       rj_data [dual_issue_pkg::issue_width];
    logic [dual_issue_pkg::xlen-1:0]                       rk_data [dual_issue_pkg::issue_width];

    assign raddr0 = in_pair[0].rj;
    assign raddr1 = in_pair[0].rk;
    assign raddr2 = in_pair[1].rj;
    assign raddr3 = in_pair[1].rk;

    assign rj_data[0] = rdata0;
    assign rk_data[0] = rdata1;
    assign rj_data[1] = rdata2;
    assign rk_data[1] = rdata3;

    // A register is busy while its producer sits in this stage or waits in a lane.
    // Bit 0 is never set, since neither source marks rd 0.
    always_comb begin
        busy = pending;
        for (int s = 0; s < dual_issue_pkg::issue_width; s++) begin
            if (vld_q[s] && !op_q[s].excp && op_q[s].rd != '0)
                busy[op_q[s].rd] = 1'b1;
        end
        hazard = 1'b0;
        for (int s = 0; s < dual_issue_pkg::issue_width; s++) begin
            if (in_pair[s].valid &&
                (busy[in_pair[s].rj] || (!in_pair[s].use_imm && busy[in_pair[s].rk])))
                hazard = 1'b1;
        end
    end

    // Nothing is taken in on a flush edge, so the flushed slot stays empty.
    assign in_allowin = out_allowin && !hazard && !flush;
    assign load       = in_valid && in_allowin;

    always_comb begin
        for (int s = 0; s < dual_issue_pkg::issue_width; s++) begin
            vld_d[s]     = in_pair[s].valid;
            op_d[s].valid = in_pair[s].valid;
            op_d[s].excp  = in_pair[s].excp;
            op_d[s].uop   = in_pair[s].uop;
            op_d[s].rd    = in_pair[s].rd;
            op_d[s].src1  = rj_data[s];
            op_d[s].src2  = in_pair[s].use_imm ? in_pair[s].imm : rk_data[s];
            op_d[s].pc    = in_pair[s].pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            vld_q <= '0;
        else if (flush)
            vld_q <= '0;
        else if (load)
            vld_q <= vld_d;
        else if (out_allowin)
            vld_q <= '0;   // Bubble: the lanes drain but nothing new is ready.
    end

    always_ff @(posedge clk) begin
        if (load)
            op_q <= op_d;
    end

    always_comb begin
        ex_op0       = op_q[0];
        ex_op0.valid = vld_q[0];
        ex_op1       = op_q[1];
        ex_op1.valid = vld_q[1];
    end

    // A pair being flushed must not reach the lanes either.
    assign ex_go = (|vld_q) && !flush;

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> vld_q == '0);

    a_no_load_on_hazard: assert property (@(posedge clk) disable iff (!rst_n)
        hazard |=> (vld_q == '0) || ($stable(vld_q) && $stable(op_q)));

endmodule

// ==== design/alu_lane.sv ====
`timescale 1ns/1ps

module alu_lane (
    input  logic                     clk,
    input  logic                     rst_n,
    input  dual_issue_pkg::lane_op_t op,
    input  logic                     go,
    input  logic                     out_allowin,
    output dual_issue_pkg::result_t  res
);

    logic [dual_issue_pkg::xlen-1:0] alu_out;
    logic [4:0]                      shamt;
    dual_issue_pkg::result_t         res_d;
    dual_issue_pkg::result_t         res_q;
    logic                            vld_q;

    always_comb begin
        shamt = op.src2[4:0];
        case (op.uop)
            dual_issue_pkg::uop_add: alu_out = op.src1 + op.src2;
            dual_issue_pkg::uop_sub: alu_out = op.src1 - op.src2;
            dual_issue_pkg::uop_and: alu_out = op.src1 & op.src2;
            dual_issue_pkg::uop_or:  alu_out = op.src1 | op.src2;
            dual_issue_pkg::uop_xor: alu_out = op.src1 ^ op.src2;
            dual_issue_pkg::uop_sll: alu_out = op.src1 << shamt;
            dual_issue_pkg::uop_srl: alu_out = op.src1 >> shamt;
            dual_issue_pkg::uop_lui: alu_out = op.src2 << 12;
            default:                 alu_out = '0;
        endcase
    end

    always_comb begin
        res_d.valid = op.valid;
        res_d.we    = op.valid && !op.excp && op.rd != '0;
        res_d.rd    = op.rd;
        res_d.data  = alu_out;
        res_d.pc    = op.pc;
    end

    // With out_allowin low the lane holds; otherwise it takes a result or a bubble.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            vld_q <= 1'b0;
        else if (out_allowin)
            vld_q <= go && op.valid;
    end

    always_ff @(posedge clk) begin
        if (go && out_allowin)
            res_q <= res_d;
    end

    always_comb begin
        res       = res_q;
        res.valid = vld_q;
        res.we    = vld_q && res_q.we;
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (res.valid && !out_allowin) |=> $stable(res));

endmodule

// ==== design/wb_merge.sv ====
`timescale 1ns/1ps

module wb_merge (
    input  dual_issue_pkg::result_t               res0,
    input  dual_issue_pkg::result_t               res1,
    input  logic                                  out_allowin,
    output logic                                  we0,
    output logic                                  we1,
    output logic [dual_issue_pkg::reg_addr_w-1:0] waddr0,
    output logic [dual_issue_pkg::reg_addr_w-1:0] waddr1,
    output logic [dual_issue_pkg::xlen-1:0]       wdata0,
    output logic [dual_issue_pkg::xlen-1:0]       wdata1,
    output logic [dual_issue_pkg::num_regs-1:0]   pending,
    output dual_issue_pkg::result_t               out_res0,
    output dual_issue_pkg::result_t               out_res1
);

    logic wr0;
    logic wr1;
    logic same_rd;

    assign wr1     = res1.valid && res1.we;
    assign same_rd = res0.rd == res1.rd;

    // Slot 0 loses a shared destination, so the file's port order does not matter.
    assign wr0 = res0.valid && res0.we && !(wr1 && same_rd);

    // Writes land only on the edge where the results retire.
    assign we0    = wr0 && out_allowin;
    assign we1    = wr1 && out_allowin;
    assign waddr0 = res0.rd;
    assign waddr1 = res1.rd;
    assign wdata0 = res0.data;
    assign wdata1 = res1.data;

    // Results stalled at retire still owe their writes, and readers must wait.
    always_comb begin
        pending = '0;
        if (!out_allowin) begin
            if (res0.valid && res0.we)
                pending[res0.rd] = 1'b1;
            if (wr1)
                pending[res1.rd] = 1'b1;
        end
    end

    assign out_res0 = res0;
    assign out_res1 = res1;

endmodule

// ==== design/dual_issue_top.sv ====
`timescale 1ns/1ps

module dual_issue_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  dual_issue_pkg::issue_pair_t in_pair,
    input  logic                        in_valid,
    output logic                        in_allowin,
    input  logic                        out_allowin,
    output dual_issue_pkg::result_t     out_res0,
    output dual_issue_pkg::result_t     out_res1
);

    dual_issue_pkg::lane_op_t              ex_op0;
    dual_issue_pkg::lane_op_t              ex_op1;
    logic                                  ex_go;
    dual_issue_pkg::result_t               res0;
    dual_issue_pkg::result_t               res1;
    logic [dual_issue_pkg::num_regs-1:0]   pending;
    logic                                  we0;
    logic                                  we1;
    logic [dual_issue_pkg::reg_addr_w-1:0] waddr0;
    logic [dual_issue_pkg::reg_addr_w-1:0] waddr1;
    logic [dual_issue_pkg::xlen-1:0]       wdata0;
    logic [dual_issue_pkg::xlen-1:0]       wdata1;
    logic [dual_issue_pkg::reg_addr_w-1:0] raddr0;
    logic [dual_issue_pkg::reg_addr_w-1:0] raddr1;
    logic [dual_issue_pkg::reg_addr_w-1:0] raddr2;
    logic [dual_issue_pkg::reg_addr_w-1:0] raddr3;
    logic [dual_issue_pkg::xlen-1:0]       rdata0;
    logic [dual_issue_pkg::xlen-1:0]       rdata1;
    logic [dual_issue_pkg::xlen-1:0]       rdata2;
    logic [dual_issue_pkg::xlen-1:0]       rdata3;

    reg_read_stage u_rr (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .in_pair(in_pair), .in_valid(in_valid), .in_allowin(in_allowin),
        .out_allowin(out_allowin), .pending(pending),
        .raddr0(raddr0), .raddr1(raddr1), .raddr2(raddr2), .raddr3(raddr3),
        .rdata0(rdata0), .rdata1(rdata1), .rdata2(rdata2), .rdata3(rdata3),
        .ex_op0(ex_op0), .ex_op1(ex_op1), .ex_go(ex_go)
    );

    alu_lane lane0 (
        .clk(clk), .rst_n(rst_n), .op(ex_op0), .go(ex_go),
        .out_allowin(out_allowin), .res(res0)
    );

    alu_lane lane1 (
        .clk(clk), .rst_n(rst_n), .op(ex_op1), .go(ex_go),
        .out_allowin(out_allowin), .res(res1)
    );

    wb_merge u_merge (
        .res0(res0), .res1(res1), .out_allowin(out_allowin),
        .we0(we0), .we1(we1), .waddr0(waddr0), .waddr1(waddr1),
        .wdata0(wdata0), .wdata1(wdata1), .pending(pending),
        .out_res0(out_res0), .out_res1(out_res1)
    );

    regfile u_rf (
        .clk(clk), .rst_n(rst_n),
        .we0(we0), .waddr0(waddr0), .wdata0(wdata0),
        .we1(we1), .waddr1(waddr1), .wdata1(wdata1),
        .raddr0(raddr0), .raddr1(raddr1), .raddr2(raddr2), .raddr3(raddr3),
        .rdata0(rdata0), .rdata1(rdata1), .rdata2(rdata2), .rdata3(rdata3)
    );

endmodule

// ==== tb/tb_dual_issue.sv ====
`timescale 1ns/1ps

module tb_dual_issue;

    localparam int num_cycles     = 3000;
    localparam int clk_period     = 4;
    localparam int timeout_cycles = 3 * num_cycles + 2000;

    logic                        clk;
    logic                        rst_n;
    logic                        flush;
    dual_issue_pkg::issue_pair_t in_pair;
    logic                        in_valid;
    logic                        in_allowin;
    logic                        out_allowin;
    dual_issue_pkg::result_t     out_res0;
    dual_issue_pkg::result_t     out_res1;

    logic [31:0]                 lfsr;
    logic [31:0]                 mregs [32];    // Architectural state as the model sees it.
    dual_issue_pkg::issue_pair_t model_q [$];   // Accepted pairs, oldest first.
    logic                        in_stage;      // Newest queued pair still sits in the stage.
    logic                        accepted_now;
    logic                        hold_prev;
    dual_issue_pkg::result_t     prev_res0;
    dual_issue_pkg::result_t     prev_res1;
    int                          n_retired;
    int                          n_flushed;

    dual_issue_top i_dut (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .in_pair(in_pair), .in_valid(in_valid), .in_allowin(in_allowin),
        .out_allowin(out_allowin), .out_res0(out_res0), .out_res1(out_res1)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Galois LFSR, one step per bit handed out.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_model(input logic [3:0] uop, input logic [31:0] a,
                                              input logic [31:0] b);
        case (uop)
            dual_issue_pkg::uop_add: return a + b;
            dual_issue_pkg::uop_sub: return a - b;
            dual_issue_pkg::uop_and: return a & b;
            dual_issue_pkg::uop_or:  return a | b;
            dual_issue_pkg::uop_xor: return a ^ b;
            dual_issue_pkg::uop_sll: return a << b[4:0];
            dual_issue_pkg::uop_srl: return a >> b[4:0];
            dual_issue_pkg::uop_lui: return b << 12;
            default:                 return 32'h0;
        endcase
    endfunction

    task automatic check(input string name, input logic [95:0] expected,
                         input logic [95:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic retire_pair();
        dual_issue_pkg::issue_pair_t p;
        dual_issue_pkg::result_t     act;
        logic [31:0]                 src2;
        logic [31:0]                 data [2];
        logic                        wen [2];
        string                       tag;
        if (model_q.size() == 0) begin
            $display("ERROR: a result retired while no accepted pair was outstanding");
            $display("Testbench failed");
            $fatal(1, "Unexpected retire");
        end else begin
            p = model_q.pop_front();
            for (int s = 0; s < 2; s++) begin
                act     = (s == 0) ? out_res0 : out_res1;
                tag     = $sformatf("pair %0d slot %0d", n_retired, s);
                src2    = p[s].use_imm ? p[s].imm : mregs[p[s].rk];
                data[s] = alu_model(p[s].uop, mregs[p[s].rj], src2);
                wen[s]  = p[s].valid && !p[s].excp && p[s].rd != '0;
                check({tag, " valid"}, p[s].valid, act.valid);
                check({tag, " we"}, wen[s], act.we);
                if (p[s].valid) begin
                    check({tag, " rd"}, p[s].rd, act.rd);
                    check({tag, " data"}, data[s], act.data);
                    check({tag, " pc"}, p[s].pc, act.pc);
                end
            end
            // Both slots read the old values. Slot 1 is written last and wins.
            if (wen[0])
                mregs[p[0].rd] = data[0];
            if (wen[1])
                mregs[p[1].rd] = data[1];
            n_retired++;
        end
    endtask

    // Called once per cycle, after the inputs for the coming edge have settled.
    task automatic model_step();
        if (hold_prev) begin
            check("out_res0 held", prev_res0, out_res0);
            check("out_res1 held", prev_res1, out_res1);
        end
        // With nothing in flight there is no hazard. Only out_allowin and flush gate the input.
        if (model_q.size() == 0)
            check("in_allowin when idle", out_allowin && !flush, in_allowin);
        if (out_allowin && (out_res0.valid || out_res1.valid))
            retire_pair();
        accepted_now = in_valid && in_allowin;
        if (flush) begin
            if (in_stage) begin
                void'(model_q.pop_back());
                n_flushed++;
            end
            in_stage = 1'b0;
        end else if (accepted_now) begin
            in_stage = in_pair[0].valid || in_pair[1].valid;
            if (in_stage)
                model_q.push_back(in_pair);
        end else if (out_allowin) begin
            in_stage = 1'b0;   // The stage empties into the lanes.
        end
        prev_res0 = out_res0;
        prev_res1 = out_res1;
        hold_prev = !out_allowin;
    endtask

    task automatic drive_random();
        dual_issue_pkg::issue_pair_t p;
        out_allowin = take_bits(2) != 0;
        flush       = out_allowin && take_bits(4) == 0;
        in_valid    = take_bits(2) != 0;
        for (int s = 0; s < 2; s++) begin
            p[s].valid   = take_bits(3) != 0;
            p[s].excp    = take_bits(4) == 0;
            p[s].uop     = 4'(take_bits(3));
            p[s].use_imm = take_bits(1) != 0;
            p[s].rd      = 5'(take_bits(3));   // Registers 0 to 7 only, so hazards are common.
            p[s].rj      = 5'(take_bits(3));
            p[s].rk      = 5'(take_bits(3));
            p[s].imm     = take_bits(32);
            p[s].pc      = take_bits(32);
        end
        in_pair = p;
    endtask

    task automatic drain();
        while (model_q.size() != 0) begin
            @(negedge clk);
            in_valid    = 1'b0;
            flush       = 1'b0;
            out_allowin = 1'b1;
            #1;
            model_step();
        end
    endtask

    // Each slot adds zero to one register and writes r0, so the data shows the final state.
    task automatic read_back();
        dual_issue_pkg::issue_pair_t p;
        int                          b;
        b = 0;
        while (b < 4) begin
            @(negedge clk);
            for (int s = 0; s < 2; s++) begin
                p[s]         = '0;
                p[s].valid   = 1'b1;
                p[s].uop     = dual_issue_pkg::uop_add;
                p[s].use_imm = 1'b1;
                p[s].rj      = 5'(2 * b + s);
                p[s].pc      = 32'h0000_1000 + 32'(8 * b + 4 * s);
            end
            in_pair     = p;
            in_valid    = 1'b1;
            flush       = 1'b0;
            out_allowin = 1'b1;
            #1;
            model_step();
            if (accepted_now)
                b++;
        end
    endtask

    initial begin
        #(timeout_cycles * clk_period);
        $display("ERROR: watchdog expired after %0d cycles before the test finished",
                 timeout_cycles);
        $display("Testbench failed");
        $fatal(1, "Timeout");
    end

    initial begin
        lfsr         = 32'd1726;
        rst_n        = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_pair      = '0;
        out_allowin  = 1'b0;
        in_stage     = 1'b0;
        accepted_now = 1'b0;
        hold_prev    = 1'b0;
        n_retired    = 0;
        n_flushed    = 0;
        for (int r = 0; r < 32; r++)
            mregs[r] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int c = 0; c < num_cycles; c++) begin
            @(negedge clk);
            drive_random();
            #1;
            model_step();
        end
        drain();
        read_back();
        drain();
        $display("Retired %0d pairs, dropped %0d on flush", n_retired, n_flushed);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/dual_issue_pkg.sv
design/regfile.sv
design/reg_read_stage.sv
design/alu_lane.sv
design/wb_merge.sv
design/dual_issue_top.sv
tb/tb_dual_issue.sv

// ==== Bender.yml ====
package:
  name: dual_issue

sources:
  - files:
      - design/dual_issue_pkg.sv
      - design/regfile.sv
      - design/reg_read_stage.sv
      - design/alu_lane.sv
      - design/wb_merge.sv
      - design/dual_issue_top.sv
  - target: test
    files:
      - tb/tb_dual_issue.sv
